// File: common/erx_pkg.sv
package erx_pkg;

   // Link and mesh widths
   localparam int PW = 104;                       // Mesh packet width
   localparam int AW = 32;                        // Address width
   localparam int DW = 32;                        // Data width

   // Mesh ID of this node, matched against dstaddr[31:20]
   localparam logic [11:0] RX_ID = 12'h800;

   // Packet queue sizing
   localparam int FIFO_AW        = 4;             // 16 entries
   localparam int FIFO_PROG_FULL = 12;            // Leaves 4 slots for in-flight packets

   // Transfer size
   typedef enum logic [1:0] {
      DM_BYTE   = 2'b00,                          // 8 bit
      DM_HALF   = 2'b01,                          // 16 bit
      DM_WORD   = 2'b10,                          // 32 bit
      DM_DOUBLE = 2'b11                           // 64 bit
   } datamode_e;

   // Decoder position within a two-beat transaction
   typedef enum logic {
      RX_HEADER  = 1'b0,                          // Expecting dstaddr and control
      RX_PAYLOAD = 1'b1                           // Expecting srcaddr and data
   } rx_state_e;

   // Mesh packet, MSB first
   typedef struct packed {
      logic [AW-1:0] srcaddr;                     // 103:72
      logic [DW-1:0] data;                        // 71:40
      logic [AW-1:0] dstaddr;                     // 39:8
      logic [3:0]    ctrlmode;                    // 7:4
      datamode_e     datamode;                    // 3:2
      logic          write;                       // 1
      logic          access;                      // 0
   } emesh_packet_t;

   // One deserialized link beat
   typedef struct packed {
      logic [7:0]  frame;                         // Nonzero while a transaction is on
      logic [63:0] data;                          // Eight link bytes
   } rx_beat_t;

endpackage

// File: erx_protocol/erx_protocol.sv
`timescale 1ns/1ps

module erx_protocol (
   input  logic                  rx_lclk_div4,    // Link clock divided by 4
   input  logic                  reset,           // Async, active high
   input  logic                  rx_enable,       // Drop packets when low
   input  erx_pkg::rx_beat_t     rx_beat,         // Parallel link beat
   output logic                  pkt_valid,       // One-cycle strobe per packet
   output erx_pkg::emesh_packet_t pkt             // Decoded packet
);

   logic [7:0]          frame_q;                  // Registered frame byte
   logic [63:0]         data_q;                   // Registered data word
   logic                enable_q;                 // Enable aligned with the beat
   erx_pkg::rx_state_e  state_q;                  // Header or payload
   logic [31:0]         dstaddr_q;                // Latched from header beat
   logic [3:0]          ctrlmode_q;
   erx_pkg::datamode_e  datamode_q;
   logic                write_q;
   logic                beat_on;                  // A transaction beat is present

   assign beat_on = (frame_q != 8'h00);

   // Input stage, frame and enable travel together with the data
   always_ff @(posedge rx_lclk_div4 or posedge reset)
   begin
      if (reset)
      begin
         frame_q  <= 8'h00;
         enable_q <= 1'b0;
      end
      else
      begin
         frame_q  <= rx_beat.frame;
         enable_q <= rx_enable;
      end
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      data_q <= rx_beat.data;                     // Payload path, no reset
   end

   // Beat tracking, a zero frame always restarts at the header
   always_ff @(posedge rx_lclk_div4 or posedge reset)
   begin
      if (reset)
         state_q <= erx_pkg::RX_HEADER;
      else if (beat_on && state_q == erx_pkg::RX_HEADER)
         state_q <= erx_pkg::RX_PAYLOAD;
      else
         state_q <= erx_pkg::RX_HEADER;            // After payload or on idle
   end

   // Header fields held until the payload beat
   always_ff @(posedge rx_lclk_div4)
   begin
      if (beat_on && state_q == erx_pkg::RX_HEADER)
      begin
         dstaddr_q  <= data_q[63:32];
         ctrlmode_q <= data_q[7:4];
         datamode_q <= erx_pkg::datamode_e'(data_q[3:2]);
         write_q    <= data_q[1];
      end
   end

   // Valid strobe, only for enabled payload beats
   always_ff @(posedge rx_lclk_div4 or posedge reset)
   begin
      if (reset)
         pkt_valid <= 1'b0;
      else
         pkt_valid <= beat_on && enable_q && (state_q == erx_pkg::RX_PAYLOAD);
   end

   // Packet assembly on the payload beat
   always_ff @(posedge rx_lclk_div4)
   begin
      if (beat_on && state_q == erx_pkg::RX_PAYLOAD)
      begin
         pkt.srcaddr  <= data_q[63:32];
         pkt.data     <= data_q[31:0];
         pkt.dstaddr  <= dstaddr_q;
         pkt.ctrlmode <= ctrlmode_q;
         pkt.datamode <= datamode_q;
         pkt.write    <= write_q;
         pkt.access   <= 1'b1;                    // Every decoded packet is an access
      end
   end

endmodule

// File: hdl/erx_disty.sv
`timescale 1ns/1ps

module erx_disty (
   input  logic                   pkt_valid,      // Strobe from decoder
   input  erx_pkg::emesh_packet_t pkt,            // Packet from decoder
   input  logic                   wr_prog_full,   // Write queue nearly full
   input  logic                   rd_prog_full,   // Read-request queue nearly full
   input  logic                   rr_prog_full,   // Read-response queue nearly full
   output logic                   wr_push,        // Into write queue
   output logic                   rd_push,        // Into read-request queue
   output logic                   rr_push,        // Into read-response queue
   output logic                   rx_wr_wait,     // Link back-pressure for writes
   output logic                   rx_rd_wait      // Link back-pressure for reads
);

   logic       to_node;                           // Destination ID matches this node
   logic [11:0] dst_id;                           // Top of dstaddr
   logic       is_read;
   logic       is_resp;

   // Destination ID sits in the upper 12 address bits
   assign dst_id  = pkt.dstaddr[erx_pkg::AW-1 -: 12];
   assign to_node = (dst_id == erx_pkg::RX_ID);

   // A write back to our own ID returns read data
   assign is_read = ~pkt.write;
   assign is_resp = pkt.write & to_node;

   // Exactly one push per valid packet
   always_comb
   begin
      wr_push = 1'b0;
      rd_push = 1'b0;
      rr_push = 1'b0;
      if (pkt_valid)
      begin
         if (is_read)
            rd_push = 1'b1;                       // Read request
         else if (is_resp)
            rr_push = 1'b1;                       // Read response
         else
            wr_push = 1'b1;                       // Plain write
      end
   end

   // Writes and responses share the link write channel
   assign rx_wr_wait = wr_prog_full | rr_prog_full;

   // Reads have their own wait line
   assign rx_rd_wait = rd_prog_full;

endmodule

// File: hdl/erx_fifo.sv
`timescale 1ns/1ps

module erx_fifo (
   input  logic                   rx_lclk_div4,   // Single clock for both sides
   input  logic                   reset,          // Async, active high
   input  logic                   push,           // Write strobe
   input  erx_pkg::emesh_packet_t din,            // Packet to queue
   input  logic                   wait_in,        // Consumer stall
   output logic                   access,         // Head is valid
   output erx_pkg::emesh_packet_t dout,           // Head packet
   output logic                   prog_full       // Occupancy at threshold
);

   logic [erx_pkg::PW-1:0]      mem [2**erx_pkg::FIFO_AW];  // Packet storage
   logic [erx_pkg::FIFO_AW-1:0] wr_ptr_q;         // Next slot to write
   logic [erx_pkg::FIFO_AW-1:0] rd_ptr_q;         // Current head
   logic [erx_pkg::FIFO_AW:0]   count_q;          // 0 to 16 entries
   logic                        full;
   logic                        wr_en;
   logic                        rd_en;

   // MSB of the count is set only at 16 entries
   assign full  = count_q[erx_pkg::FIFO_AW];
   assign wr_en = push & ~full;                   // Overflow drops the packet
   assign rd_en = access & ~wait_in;              // Transfer this cycle

   // Head is shown straight from the array
   assign access    = (count_q != '0);
   assign dout      = erx_pkg::emesh_packet_t'(mem[rd_ptr_q]);
   assign prog_full = (count_q >= (erx_pkg::FIFO_AW+1)'(erx_pkg::FIFO_PROG_FULL));

   // Storage write
   always_ff @(posedge rx_lclk_div4)
   begin
      if (wr_en)
         mem[wr_ptr_q] <= din;
   end

   // Pointers wrap naturally at 16
   always_ff @(posedge rx_lclk_div4 or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (rd_en)
            rd_ptr_q <= rd_ptr_q + 1'b1;
      end
   end

   // Occupancy, simultaneous push and pop leaves it unchanged
   always_ff @(posedge rx_lclk_div4 or posedge reset)
   begin
      if (reset)
         count_q <= '0;
      else if (wr_en && !rd_en)
         count_q <= count_q + 1'b1;
      else if (rd_en && !wr_en)
         count_q <= count_q - 1'b1;
   end

endmodule

// File: hdl/erx.sv
`timescale 1ns/1ps

module erx (
   input  logic                   rx_lclk_div4,   // Link clock divided by 4
   input  logic                   reset,          // Async, active high
   input  logic                   rx_enable,      // Receiver on
   input  erx_pkg::rx_beat_t      rx_beat,        // Deserialized link beat
   output logic                   rx_wr_wait,     // To link sender, writes
   output logic                   rx_rd_wait,     // To link sender, reads
   // Write port
   output logic                   rxwr_access,
   output erx_pkg::emesh_packet_t rxwr_packet,
   input  logic                   rxwr_wait,
   // Read-request port
   output logic                   rxrd_access,
   output erx_pkg::emesh_packet_t rxrd_packet,
   input  logic                   rxrd_wait,
   // Read-response port
   output logic                   rxrr_access,
   output erx_pkg::emesh_packet_t rxrr_packet,
   input  logic                   rxrr_wait
);

   logic                   pkt_valid;             // Decoder strobe
   erx_pkg::emesh_packet_t pkt;                   // Decoded packet, fans out to all queues
   logic                   wr_push, rd_push, rr_push;
   logic                   wr_prog_full, rd_prog_full, rr_prog_full;

   erx_protocol erx_protocol (
      .rx_lclk_div4 (rx_lclk_div4),
      .reset        (reset),
      .rx_enable    (rx_enable),
      .rx_beat      (rx_beat),
      .pkt_valid    (pkt_valid),
      .pkt          (pkt)
   );

   erx_disty erx_disty (
      .pkt_valid    (pkt_valid),
      .pkt          (pkt),
      .wr_prog_full (wr_prog_full),
      .rd_prog_full (rd_prog_full),
      .rr_prog_full (rr_prog_full),
      .wr_push      (wr_push),
      .rd_push      (rd_push),
      .rr_push      (rr_push),
      .rx_wr_wait   (rx_wr_wait),
      .rx_rd_wait   (rx_rd_wait)
   );

   erx_fifo rxwr_fifo (                           // Writes
      .rx_lclk_div4 (rx_lclk_div4), .reset (reset), .push (wr_push), .din (pkt),
      .wait_in (rxwr_wait), .access (rxwr_access), .dout (rxwr_packet),
      .prog_full (wr_prog_full)
   );

   erx_fifo rxrd_fifo (                           // Read requests
      .rx_lclk_div4 (rx_lclk_div4), .reset (reset), .push (rd_push), .din (pkt),
      .wait_in (rxrd_wait), .access (rxrd_access), .dout (rxrd_packet),
      .prog_full (rd_prog_full)
   );

   erx_fifo rxrr_fifo (                           // Read responses
      .rx_lclk_div4 (rx_lclk_div4), .reset (reset), .push (rr_push), .din (pkt),
      .wait_in (rxrr_wait), .access (rxrr_access), .dout (rxrr_packet),
      .prog_full (rr_prog_full)
   );

endmodule

// File: dv/erx_tb.sv
`timescale 1ns/1ps

module erx_tb;

   typedef struct packed {
      logic               write;                  // 0 for a read request
      erx_pkg::datamode_e datamode;
      logic [3:0]         ctrlmode;
      logic [31:0]        dstaddr;
      logic [31:0]        data;                   // From the LCG
      logic [31:0]        srcaddr;                // From the LCG
      logic               drop;                   // Sent with rx_enable low
      logic [3:0]         hold;                   // Cycles of stalled outputs afterwards
   } entry_t;

   logic                   rx_lclk_div4;
   logic                   reset;
   logic                   rx_enable;
   erx_pkg::rx_beat_t      rx_beat;
   logic                   rx_wr_wait, rx_rd_wait;
   logic                   rxwr_access, rxrd_access, rxrr_access;
   erx_pkg::emesh_packet_t rxwr_packet, rxrd_packet, rxrr_packet;
   logic                   rxwr_wait, rxrd_wait, rxrr_wait;

   entry_t                 table_q [$];           // Stimulus table
   erx_pkg::emesh_packet_t exp_q [3][$];          // Expected wr, rd, rr order
   erx_pkg::emesh_packet_t held_pkt [3];          // Head seen under wait
   logic                   held [3];
   logic [31:0]            rand_state = 32'd14094;
   logic [3:0]             hold_cnt;
   logic                   random_on;             // LCG drives the output waits
   logic                   wr_stall;              // Holds rxwr_wait high
   int                     cycles = 0;
   int                     limit = 200;
   int                     n;
   entry_t                 e;

   erx dut (.*);

   initial
   begin
      rx_lclk_div4 = 1'b0;
      forever #5 rx_lclk_div4 = ~rx_lclk_div4;    // 10 ns period
   end

   function automatic logic [31:0] next_rand();
      rand_state = rand_state * 32'd1103515245 + 32'd12345;
      return rand_state;
   endfunction

   function automatic entry_t make_entry(input logic wr, input erx_pkg::datamode_e dm,
         input logic [3:0] ctrl, input logic [31:0] dst, input logic drop,
         input logic [3:0] hold);
      entry_t t;
      t.write    = wr;
      t.datamode = dm;
      t.ctrlmode = ctrl;
      t.dstaddr  = dst;
      t.data     = next_rand();
      t.srcaddr  = next_rand();
      t.drop     = drop;
      t.hold     = hold;
      return t;
   endfunction

   // Routing rule of the link, 0 wr, 1 rd, 2 rr
   function automatic int port_of(input entry_t t);
      if (!t.write)
         return 1;
      else if (t.dstaddr[31:20] == erx_pkg::RX_ID)
         return 2;                                // Write back to this node
      else
         return 0;
   endfunction

   function automatic erx_pkg::emesh_packet_t to_packet(input entry_t t);
      erx_pkg::emesh_packet_t p;
      p.srcaddr  = t.srcaddr;
      p.data     = t.data;
      p.dstaddr  = t.dstaddr;
      p.ctrlmode = t.ctrlmode;
      p.datamode = t.datamode;
      p.write    = t.write;
      p.access   = 1'b1;
      return p;
   endfunction

   task automatic build_table();
      table_q.push_back(make_entry(1'b1, erx_pkg::DM_WORD, 4'h0, 32'h1000_0040, 1'b0, 4'd0));
      table_q.push_back(make_entry(1'b0, erx_pkg::DM_WORD, 4'h1, 32'h0840_0010, 1'b0, 4'd0));
      table_q.push_back(make_entry(1'b1, erx_pkg::DM_WORD, 4'h2, 32'h8000_0100, 1'b0, 4'd3));
      table_q.push_back(make_entry(1'b1, erx_pkg::DM_BYTE, 4'h3, 32'h1200_0000, 1'b1, 4'd0));
      table_q.push_back(make_entry(1'b0, erx_pkg::DM_HALF, 4'h4, 32'h0400_0008, 1'b1, 4'd0));
      table_q.push_back(make_entry(1'b1, erx_pkg::DM_DOUBLE, 4'h5, 32'h8001_0004, 1'b0, 4'd0));
      table_q.push_back(make_entry(1'b1, erx_pkg::DM_BYTE, 4'h6, 32'h3000_0008, 1'b0, 4'd0));
      table_q.push_back(make_entry(1'b0, erx_pkg::DM_DOUBLE, 4'h7, 32'h0123_4560, 1'b0, 4'd4));
      table_q.push_back(make_entry(1'b1, erx_pkg::DM_HALF, 4'h8, 32'h7ff0_0000, 1'b0, 4'd0));
      table_q.push_back(make_entry(1'b1, erx_pkg::DM_WORD, 4'h9, 32'h800f_fffc, 1'b0, 4'd0));
      table_q.push_back(make_entry(1'b0, erx_pkg::DM_WORD, 4'ha, 32'h8000_0200, 1'b0, 4'd0));
      table_q.push_back(make_entry(1'b1, erx_pkg::DM_WORD, 4'hb, 32'h5555_0000, 1'b1, 4'd2));
      table_q.push_back(make_entry(1'b1, erx_pkg::DM_WORD, 4'hc, 32'hffff_0000, 1'b0, 4'd0));
      table_q.push_back(make_entry(1'b0, erx_pkg::DM_BYTE, 4'hf, 32'h0000_0004, 1'b0, 4'd0));
   endtask

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check_flag(input string name, input logic want, input logic got);
      if (got !== want)
         fail_run($sformatf("[ERROR] %0t %s expected %b got %b", $time, name, want, got));
   endtask

   task automatic check_packet(input string name, input erx_pkg::emesh_packet_t want,
         input erx_pkg::emesh_packet_t got);
      if (got !== want)
         fail_run($sformatf("[ERROR] %0t %s expected %h got %h", $time, name, want, got));
   endtask

   // One clock step, inputs change 1 ns after the edge
   task automatic next_cycle();
      logic [31:0] r;
      logic [2:0]  w;
      @(posedge rx_lclk_div4);
      #1;
      r = next_rand();
      if (hold_cnt != 4'd0)
      begin
         w        = 3'b111;                       // Forced stall of all ports
         hold_cnt = hold_cnt - 4'd1;
      end
      else if (random_on)
         w = r[18:16] & r[22:20];                 // About one in four
      else
         w = 3'b000;
      rxwr_wait = w[0] | wr_stall;
      rxrd_wait = w[1];
      rxrr_wait = w[2];
   endtask

   task automatic idle_link();
      rx_beat = '0;
   endtask

   // Header beat then payload beat, link is left on the payload
   task automatic send_entry(input entry_t t);
      rx_enable     = ~t.drop;
      rx_beat.frame = 8'hff;
      rx_beat.data  = {t.dstaddr, 24'h0, t.ctrlmode, t.datamode, t.write, 1'b0};
      next_cycle();
      rx_beat.data  = {t.srcaddr, t.data};
      if (!t.drop)
         exp_q[port_of(t)].push_back(to_packet(t));
      next_cycle();
   endtask

   task automatic check_idle();
      check_flag("rxwr_access", 1'b0, rxwr_access);
      check_flag("rxrd_access", 1'b0, rxrd_access);
      check_flag("rxrr_access", 1'b0, rxrr_access);
      check_flag("rx_wr_wait", 1'b0, rx_wr_wait);
      check_flag("rx_rd_wait", 1'b0, rx_rd_wait);
   endtask

   task automatic drain_queues();
      while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0)
         next_cycle();
      repeat (4) next_cycle();                    // Late or dropped packets would show here
      check_idle();
   endtask

   // Output side model, sampled mid-cycle
   task automatic watch_port(input int p, input string name, input logic acc,
         input erx_pkg::emesh_packet_t pk, input logic w);
      erx_pkg::emesh_packet_t want;
      if (held[p])
      begin
         check_flag({name, "_access"}, 1'b1, acc);  // Must not drop under wait
         check_packet({name, "_packet"}, held_pkt[p], pk);
      end
      if (acc && !w)
      begin
         if (exp_q[p].size() == 0)
            fail_run($sformatf("Unexpected packet %h on port %s", pk, name));
         else
         begin
            want = exp_q[p].pop_front();
            check_packet({name, "_packet"}, want, pk);
         end
      end
      held[p]     = acc && w;
      held_pkt[p] = pk;
   endtask

   always @(negedge rx_lclk_div4)
   begin
      if (!reset)
      begin
         watch_port(0, "rxwr", rxwr_access, rxwr_packet, rxwr_wait);
         watch_port(1, "rxrd", rxrd_access, rxrd_packet, rxrd_wait);
         watch_port(2, "rxrr", rxrr_access, rxrr_packet, rxrr_wait);
      end
   end

   always @(posedge rx_lclk_div4)
   begin
      cycles = cycles + 1;
      if (cycles > limit)
         fail_run($sformatf("Timeout after %0d cycles, the DUT stopped delivering packets",
                            cycles));
   end

   initial
   begin
      reset     = 1'b1;
      rx_enable = 1'b0;
      rx_beat   = '0;
      rxwr_wait = 1'b0;
      rxrd_wait = 1'b0;
      rxrr_wait = 1'b0;
      hold_cnt  = 4'd0;
      random_on = 1'b0;
      wr_stall  = 1'b0;
      foreach (held[i])
         held[i] = 1'b0;
      build_table();
      limit = 40 * table_q.size() + 200;
      repeat (16) @(posedge rx_lclk_div4);
      #1;
      reset = 1'b0;
      check_idle();                               // Clean state out of reset

      // Single write, access two cycles after the payload edge
      send_entry(table_q[0]);
      idle_link();
      check_flag("rxwr_access", 1'b0, rxwr_access);
      next_cycle();
      check_flag("rxwr_access", 1'b0, rxwr_access);
      next_cycle();
      check_flag("rxwr_access", 1'b1, rxwr_access);
      drain_queues();

      // Mixed back-to-back traffic under random output waits
      random_on = 1'b1;
      for (int i = 1; i < table_q.size(); i++)
      begin
         e = table_q[i];
         while ((e.write && rx_wr_wait) || (!e.write && rx_rd_wait))
         begin
            idle_link();                          // Sender honours the link waits
            next_cycle();
         end
         send_entry(e);
         if (e.hold != 4'd0)
         begin
            idle_link();
            hold_cnt = e.hold;
            while (hold_cnt != 4'd0)
               next_cycle();
         end
      end
      idle_link();
      drain_queues();
      random_on = 1'b0;

      // Fill the write queue until the link wait rises
      wr_stall = 1'b1;
      next_cycle();
      n = 0;
      while (!rx_wr_wait)
      begin
         if (n >= 16)
            fail_run("rx_wr_wait never rose while the write queue was stalled");
         e = make_entry(1'b1, erx_pkg::DM_WORD, 4'h3, 32'h2000_0000 + 32'(n * 4), 1'b0, 4'd0);
         send_entry(e);
         idle_link();
         n = n + 1;
         check_flag("rx_wr_wait", (n - 1) >= erx_pkg::FIFO_PROG_FULL, rx_wr_wait);
         next_cycle();
         check_flag("rx_wr_wait", (n - 1) >= erx_pkg::FIFO_PROG_FULL, rx_wr_wait);
         next_cycle();
         check_flag("rx_wr_wait", n >= erx_pkg::FIFO_PROG_FULL, rx_wr_wait);  // Queued now
      end
      wr_stall = 1'b0;
      drain_queues();                             // In order, flag back low

      $display("all tests passed");
      $finish;
   end

endmodule

// File: build.f
common/erx_pkg.sv
erx_protocol/erx_protocol.sv
hdl/erx_disty.sv
hdl/erx_fifo.sv
hdl/erx.sv
dv/erx_tb.sv

// File: Makefile
# Verilator flow for the mesh link receiver

VERILATOR = verilator
FLAGS     = --timing
TOP       = erx_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
